// File: project.f
rtl/pd_pkg.sv
rtl/ir_stage.sv
rtl/opcode_decoder.sv
rtl/legality_checker.sv
rtl/decode_merge.sv
rtl/pd_top.sv
test/pd_properties.sv
test/pd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pd_tb -f project.f -o pd_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/pd_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// File: test/pd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pd_tb;

	localparam bit INOU = 1'b1;	// IN/OU trap in user mode

	logic               clk_sys = 1'b0;
	logic               rst_n;
	logic               word_valid;
	pd_pkg::instr_t     word;
	logic               q;
	logic               p;
	logic               mc_3;
	logic               si1;
	pd_pkg::r0_t        r0;
	logic               dec_ready = 1'b1;	// Driven by the stall generator
	logic               word_ready;
	logic               dec_valid;
	pd_pkg::grp_t       dec_grp;
	pd_pkg::field_t     dec_a;
	pd_pkg::field_t     dec_b;
	pd_pkg::field_t     dec_c;
	logic               dec_need_arg;
	pd_pkg::action_t    dec_action;

	logic               stall_mode = 1'b0;	// Random dec_ready drops
	logic               latency_check = 1'b0;	// Fixed latency expected
	int                 cycle = 0;	// Edge counter

	// Expected records in acceptance order
	pd_pkg::grp_t       exp_grp_q[$];
	pd_pkg::field_t     exp_a_q[$];
	pd_pkg::field_t     exp_b_q[$];
	pd_pkg::field_t     exp_c_q[$];
	logic               exp_arg_q[$];
	pd_pkg::action_t    exp_act_q[$];
	int                 exp_cyc_q[$];

	pd_top #(.INOU_USER_ILLEGAL(INOU)) dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.word_valid(word_valid), .word(word), .q(q), .p(p), .mc_3(mc_3),
		.r0(r0), .si1(si1), .word_ready(word_ready),
		.dec_ready(dec_ready), .dec_valid(dec_valid), .dec_grp(dec_grp),
		.dec_a(dec_a), .dec_b(dec_b), .dec_c(dec_c),
		.dec_need_arg(dec_need_arg), .dec_action(dec_action)
	);

	always #4 clk_sys = ~clk_sys;	// 8 ns period

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
	end

	// Consumer side, drops ready about a third of the time
	always @(posedge clk_sys) begin
		#1;
		if (stall_mode) begin
			dec_ready = ($urandom % 32'd3) != 32'd0;
		end else begin
			dec_ready = 1'b1;
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic grp_equal(input string name, input pd_pkg::grp_t got, input pd_pkg::grp_t exp);
		if (got !== exp) abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic action_equal(input string name, input pd_pkg::action_t got,
		input pd_pkg::action_t exp);
		if (got !== exp) abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic field_equal(input string name, input pd_pkg::field_t got,
		input pd_pkg::field_t exp);
		if (got !== exp) abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic bit_equal(input string name, input logic got, input logic exp);
		if (got !== exp) abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	// Group table by opcode range
	function automatic pd_pkg::grp_t group_of(input pd_pkg::opcode_t op);
		pd_pkg::grp_t g;
		if (op < 6'o20) g = pd_pkg::GRP_ILL;
		else if (op == 6'o35 || op == 6'o36) g = pd_pkg::GRP_IO;
		else if (op == 6'o37) g = pd_pkg::GRP_FP;
		else if (op < 6'o60) g = pd_pkg::GRP_NORM;
		else if (op < 6'o70) g = pd_pkg::GRP_SHORT;
		else if (op == 6'o70) g = pd_pkg::GRP_JS;
		else if (op == 6'o71) g = pd_pkg::GRP_KA2;
		else if (op == 6'o72) g = pd_pkg::GRP_C;
		else if (op == 6'o73) g = pd_pkg::GRP_S;
		else if (op == 6'o74) g = pd_pkg::GRP_J;
		else if (op == 6'o75) g = pd_pkg::GRP_L;
		else if (op == 6'o76) g = pd_pkg::GRP_G;
		else g = pd_pkg::GRP_BN;
		return g;
	endfunction

	// The eight illegal rules
	function automatic logic is_illegal(input pd_pkg::instr_t w, input pd_pkg::grp_t g,
		input logic uq, input logic um);
		pd_pkg::field_t a;
		pd_pkg::field_t b;
		a = w[7:9];
		b = w[10:12];
		return (g == pd_pkg::GRP_ILL)
			|| (g == pd_pkg::GRP_S && a >= 3'd5)
			|| (uq && g == pd_pkg::GRP_S)
			|| (uq && g == pd_pkg::GRP_BN && a < 3'd5)
			|| (uq && g == pd_pkg::GRP_IO && INOU)
			|| (g == pd_pkg::GRP_C && (b == 3'd3 || b >= 3'd4))
			|| (g == pd_pkg::GRP_C && b == 3'd1 && w[13:14] != 2'b00)
			|| (g == pd_pkg::GRP_BN && a == 3'd5 && um);
	endfunction

	// Skip flag or failed jump condition
	function automatic logic is_ineffective(input pd_pkg::instr_t w, input pd_pkg::grp_t g,
		input logic up, input pd_pkg::r0_t f);
		logic pass;
		pass = 1'b1;
		if (g == pd_pkg::GRP_J) begin
			case (w[7:9])
				3'd1: pass = f[pd_pkg::R0_L];
				3'd2: pass = f[pd_pkg::R0_E];
				3'd3: pass = f[pd_pkg::R0_G];
				3'd4: pass = f[pd_pkg::R0_Z];
				3'd5: pass = f[pd_pkg::R0_M];
				3'd6: pass = !f[pd_pkg::R0_E];
				default: pass = 1'b1;
			endcase
		end else if (g == pd_pkg::GRP_JS) begin
			case (w[7:9])
				3'd1: pass = f[pd_pkg::R0_L];
				3'd2: pass = f[pd_pkg::R0_E];
				3'd3: pass = f[pd_pkg::R0_G];
				3'd4: pass = f[pd_pkg::R0_V];
				3'd5: pass = f[pd_pkg::R0_X];
				3'd6: pass = f[pd_pkg::R0_Y];
				3'd7: pass = f[pd_pkg::R0_C];
				default: pass = 1'b1;
			endcase
		end
		return up || !pass;
	endfunction

	// Offer one word, wait for acceptance, queue its expected record
	task automatic send_word(input pd_pkg::instr_t w, input logic uq, input logic up,
		input logic um, input pd_pkg::r0_t ur, input logic us);
		pd_pkg::instr_t wi;
		pd_pkg::grp_t   g;
		int             waited;
		word_valid = 1'b1;
		word = w;
		q = uq;
		p = up;
		mc_3 = um;
		r0 = ur;
		si1 = us;
		wi = w;
		if (us) wi[0:1] = 2'b00;	// Invalidated opcode
		g = group_of(wi[0:5]);
		waited = 0;
		@(posedge clk_sys);
		while (word_ready !== 1'b1) begin
			waited++;
			if (waited > 100) abort_run("timeout, word_ready stayed low and the word was not taken");
			@(posedge clk_sys);
		end
		exp_grp_q.push_back(g);
		exp_a_q.push_back(wi[7:9]);
		exp_b_q.push_back(wi[10:12]);
		exp_c_q.push_back(wi[13:15]);
		exp_arg_q.push_back((g == pd_pkg::GRP_NORM || g == pd_pkg::GRP_IO
			|| g == pd_pkg::GRP_FP) && wi[13:15] == 3'd0);
		if (is_illegal(wi, g, uq, um)) exp_act_q.push_back(pd_pkg::ACT_TRAP);
		else if (is_ineffective(wi, g, up, ur)) exp_act_q.push_back(pd_pkg::ACT_SKIP);
		else exp_act_q.push_back(pd_pkg::ACT_EXEC);
		exp_cyc_q.push_back(cycle);
		#1;
		word_valid = 1'b0;
		si1 = 1'b0;
	endtask

	// Wait until every queued record has come out
	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (exp_grp_q.size() != 0) begin
			waited++;
			if (waited > 2000) abort_run("timeout, decoded records missing at the output");
			@(posedge clk_sys);
		end
		#1;
	endtask

	// Scoreboard on every output transfer
	always @(posedge clk_sys) begin
		if (rst_n === 1'b1 && dec_valid === 1'b1 && dec_ready === 1'b1) begin
			if (exp_grp_q.size() == 0) abort_run("record delivered with no word accepted for it");
			if (latency_check && cycle != exp_cyc_q[0] + 2) begin
				abort_run($sformatf("ERR %0t latency got %0d expected 2", $time,
					cycle - exp_cyc_q[0]));
			end
			grp_equal("dec_grp", dec_grp, exp_grp_q.pop_front());
			field_equal("dec_a", dec_a, exp_a_q.pop_front());
			field_equal("dec_b", dec_b, exp_b_q.pop_front());
			field_equal("dec_c", dec_c, exp_c_q.pop_front());
			bit_equal("dec_need_arg", dec_need_arg, exp_arg_q.pop_front());
			action_equal("dec_action", dec_action, exp_act_q.pop_front());
			void'(exp_cyc_q.pop_front());
		end
	end

	task automatic reset_check();
		bit_equal("dec_valid", dec_valid, 1'b0);
		bit_equal("word_ready", word_ready, 1'b1);
	endtask

	// All 64 opcodes, other fields random
	task automatic group_sweep();
		pd_pkg::instr_t w;
		for (int i = 0; i < 64; i++) begin
			w = pd_pkg::instr_t'($urandom);
			w[0:5] = pd_pkg::opcode_t'(i);
			send_word(w, 1'b0, 1'b0, 1'b0, pd_pkg::r0_t'($urandom), 1'b0);
		end
		drain_outputs();
	endtask

	// S, BN, IO and C with every mode, MC and A/B combination
	task automatic illegal_rules();
		pd_pkg::opcode_t ops[5] = '{6'o73, 6'o77, 6'o35, 6'o36, 6'o72};
		pd_pkg::instr_t  w;
		for (int k = 0; k < 5; k++)
			for (int m = 0; m < 4; m++)
				for (int ab = 0; ab < 64; ab++) begin
					w = pd_pkg::instr_t'($urandom);
					w[0:5] = ops[k];
					w[7:12] = 6'(ab);	// A and B together
					send_word(w, m[0], 1'b0, m[1], pd_pkg::r0_t'($urandom), 1'b0);
				end
		drain_outputs();
	endtask

	// J and JS, each A field, random flags, P set on the last two
	task automatic jump_conditions();
		pd_pkg::instr_t w;
		for (int k = 0; k < 2; k++)
			for (int a = 0; a < 8; a++)
				for (int r = 0; r < 8; r++) begin
					w = pd_pkg::instr_t'($urandom);
					w[0:5] = (k == 0) ? 6'o74 : 6'o70;
					w[7:9] = pd_pkg::field_t'(a);
					send_word(w, 1'b0, r >= 6, 1'b0, pd_pkg::r0_t'($urandom), 1'b0);
				end
		drain_outputs();
	endtask

	// Legal words taken with SI1 must trap
	task automatic invalidation();
		pd_pkg::opcode_t ops[4] = '{6'o20, 6'o60, 6'o74, 6'o77};
		pd_pkg::instr_t  w;
		int              waited;
		for (int k = 0; k < 4; k++) begin
			w = pd_pkg::instr_t'($urandom);
			w[0:5] = ops[k];
			send_word(w, 1'b0, 1'b0, 1'b0, '0, 1'b1);
			waited = 0;
			@(posedge clk_sys);
			while (dec_valid !== 1'b1) begin
				waited++;
				if (waited > 20) abort_run("timeout, invalidated word produced no record");
				@(posedge clk_sys);
			end
			grp_equal("dec_grp", dec_grp, pd_pkg::GRP_ILL);
			action_equal("dec_action", dec_action, pd_pkg::ACT_TRAP);
			drain_outputs();
		end
	endtask

	// 200 words under random stalls, then a stall-free burst with latency check
	task automatic random_stream();
		int unsigned rnd;
		stall_mode = 1'b1;
		for (int i = 0; i < 200; i++) begin
			rnd = $urandom;
			send_word(pd_pkg::instr_t'($urandom), rnd[0], rnd[1], rnd[2],
				pd_pkg::r0_t'($urandom), rnd[7:4] == 4'd0);
		end
		stall_mode = 1'b0;
		drain_outputs();
		@(posedge clk_sys);
		#1;
		latency_check = 1'b1;
		for (int i = 0; i < 100; i++) begin
			rnd = $urandom;
			send_word(pd_pkg::instr_t'($urandom), rnd[0], rnd[1], rnd[2],
				pd_pkg::r0_t'($urandom), 1'b0);
		end
		drain_outputs();
		latency_check = 1'b0;
	endtask

	initial begin
		void'($urandom(27146));
		rst_n = 1'b0;
		word_valid = 1'b0;
		word = '0;
		q = 1'b0;
		p = 1'b0;
		mc_3 = 1'b0;
		r0 = '0;
		si1 = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		reset_check();
		group_sweep();
		illegal_rules();
		jump_conditions();
		invalidation();
		random_stream();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/pd_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pd_properties (
	input wire                  clk_sys,
	input wire                  rst_n,
	input wire                  dec_valid,
	input wire                  dec_ready,
	input wire pd_pkg::grp_t    dec_grp,
	input wire pd_pkg::field_t  dec_a,
	input wire pd_pkg::field_t  dec_b,
	input wire pd_pkg::field_t  dec_c,
	input wire                  dec_need_arg,
	input wire pd_pkg::action_t dec_action
);

	// Stalled record stays put
	a_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_grp) && $stable(dec_a)
			&& $stable(dec_b) && $stable(dec_c) && $stable(dec_need_arg)
			&& $stable(dec_action))
		else $error("decoded record changed while stalled");

	// Output empty after a reset edge
	a_reset: assert property (@(posedge clk_sys) !rst_n |=> !dec_valid)
		else $error("dec_valid high after reset");

	a_action: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dec_valid |-> dec_action != 2'd3)	// Code 3 unused
		else $error("unused action code on the output");

endmodule

bind decode_merge pd_properties u_props (
	.clk_sys(clk_sys), .rst_n(rst_n), .dec_valid(dec_valid), .dec_ready(dec_ready),
	.dec_grp(dec_grp), .dec_a(dec_a), .dec_b(dec_b), .dec_c(dec_c),
	.dec_need_arg(dec_need_arg), .dec_action(dec_action)
);

`default_nettype wire

// File: rtl/pd_top.sv
`timescale 1ns/1ps
`default_nettype none

module pd_top #(
	parameter bit INOU_USER_ILLEGAL = 1'b1	// IN/OU trap in user mode
) (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	// Fetch side
	input  wire                 word_valid,
	input  wire pd_pkg::instr_t word,
	input  wire                 q,	// User mode
	input  wire                 p,	// Skip flag
	input  wire                 mc_3,
	input  wire pd_pkg::r0_t    r0,
	input  wire                 si1,	// Invalidate
	output logic                word_ready,
	// Execute side
	input  wire                 dec_ready,
	output logic                dec_valid,
	output pd_pkg::grp_t        dec_grp,
	output pd_pkg::field_t      dec_a,
	output pd_pkg::field_t      dec_b,
	output pd_pkg::field_t      dec_c,
	output logic                dec_need_arg,
	output pd_pkg::action_t     dec_action
);

	logic           ir_valid;	// IR stage state
	pd_pkg::instr_t ir;
	logic           ir_q, ir_p, ir_mc_3;	// Flags captured with IR
	pd_pkg::r0_t    ir_r0;
	logic           ir_ready;	// Merge back-pressure
	pd_pkg::grp_t   grp;	// Decoder results
	logic           need_arg;
	logic           illegal, ineffective;

	ir_stage u_ir (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.word_valid(word_valid), .word(word), .q(q), .p(p), .mc_3(mc_3),
		.r0(r0), .si1(si1), .word_ready(word_ready),
		.ir_ready(ir_ready), .ir_valid(ir_valid), .ir(ir),
		.ir_q(ir_q), .ir_p(ir_p), .ir_mc_3(ir_mc_3), .ir_r0(ir_r0)
	);

	opcode_decoder u_op (.ir(ir), .grp(grp), .need_arg(need_arg));

	legality_checker #(.INOU_USER_ILLEGAL(INOU_USER_ILLEGAL)) u_leg (
		.ir(ir), .grp(grp), .ir_q(ir_q), .ir_p(ir_p), .ir_mc_3(ir_mc_3),
		.ir_r0(ir_r0), .illegal(illegal), .ineffective(ineffective)
	);

	decode_merge u_merge (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.ir_valid(ir_valid), .ir(ir), .grp(grp), .need_arg(need_arg),
		.illegal(illegal), .ineffective(ineffective), .ir_ready(ir_ready),
		.dec_ready(dec_ready), .dec_valid(dec_valid), .dec_grp(dec_grp),
		.dec_a(dec_a), .dec_b(dec_b), .dec_c(dec_c),
		.dec_need_arg(dec_need_arg), .dec_action(dec_action)
	);

endmodule

`default_nettype wire

// File: rtl/decode_merge.sv
`timescale 1ns/1ps
`default_nettype none

module decode_merge (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	// From IR stage and decoders
	input  wire                 ir_valid,	// IR holds a word
	input  wire pd_pkg::instr_t ir,	// Latched word
	input  wire pd_pkg::grp_t   grp,	// Group code
	input  wire                 need_arg,	// Argument in next word
	input  wire                 illegal,	// Trap condition
	input  wire                 ineffective,	// Skip condition
	output logic                ir_ready,	// Merge takes IR this edge
	// Decoded record
	input  wire                 dec_ready,	// Consumer takes record
	output logic                dec_valid,	// Record present
	output pd_pkg::grp_t        dec_grp,
	output pd_pkg::field_t      dec_a,
	output pd_pkg::field_t      dec_b,
	output pd_pkg::field_t      dec_c,
	output logic                dec_need_arg,
	output pd_pkg::action_t     dec_action
);

	pd_pkg::action_t action;	// Action for the word in IR
	logic            load;	// Record register loads

	// Trap wins over skip
	always_comb begin
		if (illegal) begin
			action = pd_pkg::ACT_TRAP;
		end else if (ineffective) begin
			action = pd_pkg::ACT_SKIP;
		end else begin
			action = pd_pkg::ACT_EXEC;
		end
	end

	// Free slot or the current record leaves now
	assign ir_ready = ~dec_valid | dec_ready;
	assign load = ir_valid & ir_ready;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (ir_ready) begin
			dec_valid <= ir_valid;	// Bubble if IR empty
		end
	end

	// Held while dec_ready is low
	always_ff @(posedge clk_sys) begin
		if (load) begin
			dec_grp <= grp;
			dec_a <= ir[7:9];	// Field A
			dec_b <= ir[10:12];	// Field B
			dec_c <= ir[13:15];	// Field C
			dec_need_arg <= need_arg;
			dec_action <= action;
		end
	end

endmodule

`default_nettype wire

// File: rtl/legality_checker.sv
`timescale 1ns/1ps
`default_nettype none

module legality_checker #(
	parameter bit INOU_USER_ILLEGAL = 1'b1	// IN/OU trap in user mode
) (
	input  wire pd_pkg::instr_t ir,	// Latched word
	input  wire pd_pkg::grp_t   grp,	// Group from opcode decoder
	input  wire                 ir_q,	// User mode
	input  wire                 ir_p,	// Skip flag
	input  wire                 ir_mc_3,	// Premodification limit
	input  wire pd_pkg::r0_t    ir_r0,	// R0 flags
	output logic                illegal,
	output logic                ineffective
);

	pd_pkg::field_t fa;	// A field
	pd_pkg::field_t fb;	// B field
	logic [0:7]     a_eq;	// A field one-hot
	logic           a_hi;	// A is 5..7
	logic           b_1;	// B is 1
	logic           c_hi;	// Bits 13..14 set
	logic           g_ill, g_s, g_bn, g_io, g_c, g_j, g_js;
	logic           ill_op;	// Rules 1, 2, 6, 7, 8
	logic           ill_user;	// Rules 3, 4, 5
	logic           fail_j;	// J condition not met
	logic           fail_js;	// JS condition not met

	assign fa = ir[7:9];
	assign fb = ir[10:12];
	assign b_1 = (fb == 3'd1);
	assign c_hi = (ir[13:14] != 2'b00);

	always_comb begin
		a_eq = '0;
		a_eq[fa] = 1'b1;
	end
	assign a_hi = a_eq[5] | a_eq[6] | a_eq[7];

	assign g_ill = (grp == pd_pkg::GRP_ILL);
	assign g_s   = (grp == pd_pkg::GRP_S);
	assign g_bn  = (grp == pd_pkg::GRP_BN);
	assign g_io  = (grp == pd_pkg::GRP_IO);
	assign g_c   = (grp == pd_pkg::GRP_C);
	assign g_j   = (grp == pd_pkg::GRP_J);
	assign g_js  = (grp == pd_pkg::GRP_JS);

	// Unassigned opcodes, unused S and C codes, MD past the limit
	assign ill_op = g_ill
		| (g_s & a_hi)
		| (g_c & (fb[0] | (fb[1] & fb[2])))	// B is 3 or 4..7
		| (g_c & b_1 & c_hi)
		| (g_bn & a_eq[5] & ir_mc_3);	// MD after three premods

	// Privileged in user mode
	assign ill_user = ir_q & (g_s
		| (g_bn & ~a_hi)	// MB, IM, KI, FI, SP
		| (g_io & INOU_USER_ILLEGAL));

	assign illegal = ill_op | ill_user;

	// Group J, A 0 and 7 unconditional
	always_comb begin
		case (fa)
			3'd1: fail_j = ~ir_r0[pd_pkg::R0_L];	// JL
			3'd2: fail_j = ~ir_r0[pd_pkg::R0_E];	// JE
			3'd3: fail_j = ~ir_r0[pd_pkg::R0_G];	// JG
			3'd4: fail_j = ~ir_r0[pd_pkg::R0_Z];	// JZ
			3'd5: fail_j = ~ir_r0[pd_pkg::R0_M];	// JM
			3'd6: fail_j = ir_r0[pd_pkg::R0_E];	// JN wants E clear
			default: fail_j = 1'b0;
		endcase
	end

	// Group JS, A 0 unconditional
	always_comb begin
		case (fa)
			3'd1: fail_js = ~ir_r0[pd_pkg::R0_L];
			3'd2: fail_js = ~ir_r0[pd_pkg::R0_E];
			3'd3: fail_js = ~ir_r0[pd_pkg::R0_G];
			3'd4: fail_js = ~ir_r0[pd_pkg::R0_V];	// JVS
			3'd5: fail_js = ~ir_r0[pd_pkg::R0_X];	// JXS
			3'd6: fail_js = ~ir_r0[pd_pkg::R0_Y];	// JYS
			3'd7: fail_js = ~ir_r0[pd_pkg::R0_C];	// JCS
			default: fail_js = 1'b0;
		endcase
	end

	// P skips whatever comes next
	assign ineffective = ir_p | (g_j & fail_j) | (g_js & fail_js);

endmodule

`default_nettype wire

// File: rtl/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
	input  wire pd_pkg::instr_t ir,	// Latched instruction word
	output pd_pkg::grp_t        grp,	// Group code
	output logic                need_arg	// Argument sits in next word
);

	pd_pkg::opcode_t op;	// Opcode field
	pd_pkg::field_t  fc;	// C field
	logic            c0;	// C field is zero
	logic            g_ill;	// 000..017
	logic            g_norm;	// Normal two-argument
	logic            g_io;	// IN, OU
	logic            g_fp;	// 037
	logic            g_short;	// 060..067
	logic            g_ka;	// 070..077 block
	logic [0:7]      ka_sel;	// One-hot within 070..077

	assign op = ir[0:5];
	assign fc = ir[13:15];
	assign c0 = (fc == 3'd0);

	// Coarse split on the top opcode bits
	assign g_ill   = (op[0:1] == 2'b00);
	assign g_short = (op[0:2] == 3'b110);
	assign g_ka    = (op[0:2] == 3'b111);

	// 035..037 carved out of the 020..037 range
	assign g_io = (op == 6'o35) | (op == 6'o36);
	assign g_fp = (op == 6'o37);

	// Rest of 020..057
	assign g_norm = ~g_ill & ~g_short & ~g_ka & ~g_io & ~g_fp;

	// Low three bits pick one of eight groups
	always_comb begin
		ka_sel = '0;
		if (g_ka) begin
			ka_sel[op[3:5]] = 1'b1;
		end
	end

	// Encode the one-hot lines
	always_comb begin
		grp = pd_pkg::GRP_ILL;	// Also covers g_ill
		if (g_norm) begin
			grp = pd_pkg::GRP_NORM;
		end else if (g_io) begin
			grp = pd_pkg::GRP_IO;
		end else if (g_fp) begin
			grp = pd_pkg::GRP_FP;
		end else if (g_short) begin
			grp = pd_pkg::GRP_SHORT;
		end else if (ka_sel[0]) begin
			grp = pd_pkg::GRP_JS;	// 070
		end else if (ka_sel[1]) begin
			grp = pd_pkg::GRP_KA2;	// 071
		end else if (ka_sel[2]) begin
			grp = pd_pkg::GRP_C;	// 072
		end else if (ka_sel[3]) begin
			grp = pd_pkg::GRP_S;	// 073
		end else if (ka_sel[4]) begin
			grp = pd_pkg::GRP_J;	// 074
		end else if (ka_sel[5]) begin
			grp = pd_pkg::GRP_L;	// 075
		end else if (ka_sel[6]) begin
			grp = pd_pkg::GRP_G;	// 076
		end else if (ka_sel[7]) begin
			grp = pd_pkg::GRP_BN;	// 077
		end
	end

	// Normal argument with C=0 means the argument is the next word
	assign need_arg = (g_norm | g_io | g_fp) & c0;

endmodule

`default_nettype wire

// File: rtl/ir_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ir_stage (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	// Fetch side
	input  wire                 word_valid,	// Word offered
	input  wire pd_pkg::instr_t word,	// Instruction word
	input  wire                 q,	// User mode
	input  wire                 p,	// Skip flag
	input  wire                 mc_3,	// Three premodifications done
	input  wire pd_pkg::r0_t    r0,	// R0 flags
	input  wire                 si1,	// Invalidate at capture
	output logic                word_ready,	// Stage can take a word
	// Toward the decoders
	input  wire                 ir_ready,	// Merge takes IR this edge
	output logic                ir_valid,	// IR holds a word
	output pd_pkg::instr_t      ir,	// Instruction register
	output logic                ir_q,	// Flags latched with the word
	output logic                ir_p,
	output logic                ir_mc_3,
	output pd_pkg::r0_t         ir_r0
);

	logic           load;	// Word accepted this edge
	pd_pkg::instr_t word_in;	// Word after invalidation

	// Empty or draining, so a new word fits
	assign word_ready = ~ir_valid | ir_ready;
	assign load = word_valid & word_ready;

	// SI1 forces opcode bits 0..1 low, opcode lands in 000..017
	assign word_in = {word[0:1] & {2{~si1}}, word[2:15]};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ir_valid <= 1'b0;	// Empty after reset
		end else if (word_ready) begin
			ir_valid <= word_valid;	// Refill or drain
		end
	end

	// Word and its flags go in together
	always_ff @(posedge clk_sys) begin
		if (load) begin
			ir <= word_in;
			ir_q <= q;	// Mode at fetch time
			ir_p <= p;
			ir_mc_3 <= mc_3;
			ir_r0 <= r0;	// Later flag updates ignored
		end
	end

endmodule

`default_nettype wire

// File: rtl/pd_pkg.sv
`default_nettype none

package pd_pkg;

	// Bit 0 is the MSB throughout
	typedef logic [0:15] instr_t;	// Instruction word
	typedef logic [0:5]  opcode_t;	// Opcode, word bits 0..5
	typedef logic [0:2]  field_t;	// A, B or C register field
	typedef logic [0:8]  r0_t;	// R0 flags Z M V C L E G Y X
	typedef logic [3:0]  grp_t;	// Instruction group code
	typedef logic [1:0]  action_t;	// Decode action

	// Instruction groups by opcode range (octal)
	localparam grp_t GRP_ILL   = 4'd0;	// 000..017
	localparam grp_t GRP_NORM  = 4'd1;	// 020..034, 040..057
	localparam grp_t GRP_IO    = 4'd2;	// 035 OU, 036 IN
	localparam grp_t GRP_FP    = 4'd3;	// 037 wide/float arithmetic
	localparam grp_t GRP_SHORT = 4'd4;	// 060..067 short argument
	localparam grp_t GRP_JS    = 4'd5;	// 070
	localparam grp_t GRP_KA2   = 4'd6;	// 071
	localparam grp_t GRP_C     = 4'd7;	// 072
	localparam grp_t GRP_S     = 4'd8;	// 073 system
	localparam grp_t GRP_J     = 4'd9;	// 074 jumps
	localparam grp_t GRP_L     = 4'd10;	// 075
	localparam grp_t GRP_G     = 4'd11;	// 076
	localparam grp_t GRP_BN    = 4'd12;	// 077

	// What execute does with the instruction
	localparam action_t ACT_EXEC = 2'd0;	// Run it
	localparam action_t ACT_SKIP = 2'd1;	// Ineffective
	localparam action_t ACT_TRAP = 2'd2;	// Illegal
	// 2'd3 is never produced

	// Index of each flag inside r0_t
	localparam int R0_Z = 0;	// Zero
	localparam int R0_M = 1;	// Minus
	localparam int R0_V = 2;	// Overflow
	localparam int R0_C = 3;	// Carry
	localparam int R0_L = 4;	// Less
	localparam int R0_E = 5;	// Equal
	localparam int R0_G = 6;	// Greater
	localparam int R0_Y = 7;	// Y bit
	localparam int R0_X = 8;	// X bit

endpackage

`default_nettype wire
